// ==== src/agen_arch_pkg.sv ====
// Architectural definitions for the address generation stage
// widths, register file views, operand source, size and segment codes

`default_nettype none

package agen_arch_pkg;

    localparam int GPR_W = 32;
    localparam int SEG_W = 16;
    localparam int ADDR_W = 32;
    localparam int OPND_W = 64;
    localparam int IMM_W = 48;

    typedef logic [GPR_W-1:0] gpr_t;
    typedef logic [SEG_W-1:0] seg_sel_t;
    typedef logic [ADDR_W-1:0] lin_addr_t;
    typedef logic [OPND_W-1:0] operand_t;
    typedef logic [IMM_W-1:0] imm_t;
    typedef logic [2:0] reg_idx_t;
    typedef logic [2:0] op_src_t;
    typedef logic [2:0] op_size_t;

    // one sized value per general register, indexed by reg_idx_t
    typedef operand_t [7:0] gpr_view_t;

    typedef struct packed {
        gpr_t eax;
        gpr_t ecx;
        gpr_t edx;
        gpr_t ebx;
        gpr_t esp;
        gpr_t ebp;
        gpr_t esi;
        gpr_t edi;
        seg_sel_t es;
        seg_sel_t cs;
        seg_sel_t ss;
        seg_sel_t ds;
        seg_sel_t fs;
        seg_sel_t gs;
    } arch_regs_s;

    // operand sources, codes 3 and 4 have no function in this stage
    localparam op_src_t SRC_NONE = 3'd0;
    localparam op_src_t SRC_REG = 3'd1;
    localparam op_src_t SRC_SEG = 3'd2;
    localparam op_src_t SRC_IMM = 3'd5;
    localparam op_src_t SRC_MEM = 3'd6;
    localparam op_src_t SRC_SYS = 3'd7;

    localparam op_size_t SIZE_8 = 3'd1;
    localparam op_size_t SIZE_16 = 3'd2;
    localparam op_size_t SIZE_32 = 3'd3;

    // segment codes, 6 and 7 select a null segment
    localparam logic [2:0] SEG_ES = 3'd0;
    localparam logic [2:0] SEG_CS = 3'd1;
    localparam logic [2:0] SEG_SS = 3'd2;
    localparam logic [2:0] SEG_DS = 3'd3;
    localparam logic [2:0] SEG_FS = 3'd4;
    localparam logic [2:0] SEG_GS = 3'd5;

    // real mode: linear = segment * 16 + offset
    localparam int SEG_SHIFT = 4;

    function automatic seg_sel_t seg_select(arch_regs_s regs, logic [2:0] code);
        case (code)
            SEG_ES: return regs.es;
            SEG_CS: return regs.cs;
            SEG_SS: return regs.ss;
            SEG_DS: return regs.ds;
            SEG_FS: return regs.fs;
            SEG_GS: return regs.gs;
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/agen_uop_pkg.sv ====
// Micro-op records for the address generation stage
// request from register access and result toward memory access

`default_nettype none

package agen_uop_pkg;

    import agen_arch_pkg::*;

    typedef struct packed {
        op_size_t size;
        logic set_d_flag;
        logic clear_d_flag;
        op_src_t op0_src;
        op_src_t op1_src;
        reg_idx_t op0_reg;
        reg_idx_t op1_reg;
        imm_t imm;
        logic [3:0] alu_op;
        logic [2:0] flag_0;
        logic [2:0] flag_1;
        // bit 1 marks a pop
        logic [1:0] stack_op;
        lin_addr_t stack_address;
        logic [2:0] seg_override;
        logic seg_override_valid;
        lin_addr_t pc;
        logic branch_taken;
        logic [15:0] opcode;
    } agen_req_s;

    typedef struct packed {
        op_size_t size;
        logic set_d_flag;
        logic clear_d_flag;
        operand_t op0;
        operand_t op1;
        reg_idx_t op0_reg;
        reg_idx_t op1_reg;
        logic op0_is_reg;
        logic op0_is_segment;
        logic op1_is_reg;
        logic op1_is_address;
        imm_t imm;
        logic [3:0] alu_op;
        logic [2:0] flag_0;
        logic [2:0] flag_1;
        logic [1:0] stack_op;
        lin_addr_t stack_address;
        lin_addr_t pc;
        logic branch_taken;
        logic [15:0] opcode;
        logic to_sys_controller;
    } agen_resp_s;

endpackage

`default_nettype wire

// ==== src/reg_size_selector.sv ====
// General register size selector
// zero-extends the eight registers to 8, 16 or 32 bits by size code

`timescale 1ns/1ps
`default_nettype none

module reg_size_selector (
    input  agen_arch_pkg::op_size_t   size,
    input  agen_arch_pkg::arch_regs_s regs,
    output agen_arch_pkg::gpr_view_t  view
);

    import agen_arch_pkg::*;

    gpr_t gpr [8];
    logic [7:0] byte_reg [8];

    assign gpr[0] = regs.eax;
    assign gpr[1] = regs.ecx;
    assign gpr[2] = regs.edx;
    assign gpr[3] = regs.ebx;
    assign gpr[4] = regs.esp;
    assign gpr[5] = regs.ebp;
    assign gpr[6] = regs.esi;
    assign gpr[7] = regs.edi;

    // al cl dl bl, then ah ch dh bh
    assign byte_reg[0] = regs.eax[7:0];
    assign byte_reg[1] = regs.ecx[7:0];
    assign byte_reg[2] = regs.edx[7:0];
    assign byte_reg[3] = regs.ebx[7:0];
    assign byte_reg[4] = regs.eax[15:8];
    assign byte_reg[5] = regs.ecx[15:8];
    assign byte_reg[6] = regs.edx[15:8];
    assign byte_reg[7] = regs.ebx[15:8];

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            case (size)
                SIZE_32: view[i] = operand_t'(gpr[i]);
                SIZE_16: view[i] = operand_t'(gpr[i][15:0]);
                SIZE_8:  view[i] = operand_t'(byte_reg[i]);
                // mmx and 64-bit sizes not handled here
                default: view[i] = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/string_address_unit.sv ====
// Real-mode string address unit
// op0 destination at ES:EDI, op1 source at DS:ESI or the override segment

`timescale 1ns/1ps
`default_nettype none

module string_address_unit (
    input  agen_arch_pkg::arch_regs_s regs,
    input  logic [2:0]                seg_override,
    input  logic                      seg_override_valid,
    output agen_arch_pkg::lin_addr_t  dst_addr,
    output agen_arch_pkg::lin_addr_t  src_addr
);

    import agen_arch_pkg::*;

    seg_sel_t src_seg;

    // destination segment is always ES
    assign dst_addr = (lin_addr_t'(regs.es) << SEG_SHIFT) + regs.edi;

    // null segment codes come back as zero
    assign src_seg = seg_override_valid ? seg_select(regs, seg_override) : regs.ds;

    assign src_addr = (lin_addr_t'(src_seg) << SEG_SHIFT) + regs.esi;

endmodule

`default_nettype wire

// ==== src/operand_mux.sv ====
// Operand select for one operand slot
// picks register, segment, immediate or string address by source code

`timescale 1ns/1ps
`default_nettype none

module operand_mux (
    input  agen_arch_pkg::op_src_t    src,
    input  agen_arch_pkg::reg_idx_t   reg_sel,
    input  agen_arch_pkg::gpr_view_t  view,
    input  agen_arch_pkg::arch_regs_s regs,
    input  agen_arch_pkg::imm_t       imm,
    input  agen_arch_pkg::lin_addr_t  mem_addr,
    output agen_arch_pkg::operand_t   operand,
    output logic                      is_reg,
    output logic                      is_segment,
    output logic                      is_mem
);

    import agen_arch_pkg::*;

    always_comb begin
        case (src)
            SRC_REG:  operand = view[reg_sel];
            SRC_SEG:  operand = operand_t'(seg_select(regs, reg_sel));
            SRC_IMM:  operand = operand_t'(imm);
            SRC_MEM:  operand = operand_t'(mem_addr);
            // none, mod r/m and system codes carry no operand
            default:  operand = '0;
        endcase
    end

    assign is_reg = (src == SRC_REG);
    assign is_segment = (src == SRC_SEG);
    assign is_mem = (src == SRC_MEM);

endmodule

`default_nettype wire

// ==== src/uop_assembler.sv ====
// Result assembly for the address generation stage
// stack pop override on op1, system controller marking, field copy

`timescale 1ns/1ps
`default_nettype none

module uop_assembler (
    input  agen_uop_pkg::agen_req_s  req,
    input  agen_arch_pkg::operand_t  op0,
    input  agen_arch_pkg::operand_t  op1,
    input  logic                     op0_is_reg,
    input  logic                     op0_is_segment,
    input  logic                     op1_is_reg,
    input  logic                     op1_is_mem,
    output agen_uop_pkg::agen_resp_s resp
);

    import agen_arch_pkg::*;
    import agen_uop_pkg::*;

    logic is_pop;

    assign is_pop = req.stack_op[1];

    always_comb begin
        resp.size = req.size;
        resp.set_d_flag = req.set_d_flag;
        resp.clear_d_flag = req.clear_d_flag;
        resp.op0 = op0;
        // a pop reads its operand from the top of stack
        resp.op1 = is_pop ? operand_t'(req.stack_address) : op1;
        resp.op0_reg = req.op0_reg;
        resp.op1_reg = req.op1_reg;
        resp.op0_is_reg = op0_is_reg;
        resp.op0_is_segment = op0_is_segment;
        resp.op1_is_reg = op1_is_reg;
        resp.op1_is_address = op1_is_mem | is_pop;
        resp.imm = req.imm;
        resp.alu_op = req.alu_op;
        resp.flag_0 = req.flag_0;
        resp.flag_1 = req.flag_1;
        resp.stack_op = req.stack_op;
        resp.stack_address = req.stack_address;
        resp.pc = req.pc;
        resp.branch_taken = req.branch_taken;
        resp.opcode = req.opcode;
        resp.to_sys_controller = (req.op0_src == SRC_SYS);
    end

endmodule

`default_nettype wire

// ==== src/pipe_stage.sv ====
// Single entry valid/ready pipeline register
// accepts when empty or draining, flush drops the held and incoming entry

`timescale 1ns/1ps
`default_nettype none

module pipe_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  agen_uop_pkg::agen_resp_s in_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output agen_uop_pkg::agen_resp_s out_data
);

    import agen_uop_pkg::*;

    agen_resp_s data_q;

    // room when empty or when the held entry leaves this cycle
    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves on a transfer, held under back-pressure
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_data = data_q;

endmodule

`default_nettype wire

// ==== src/agen_top.sv ====
// Address generation stage top level
// operand formation for op0/op1 followed by one pipeline register

`timescale 1ns/1ps
`default_nettype none

module agen_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      flush,
    input  logic                      r_valid,
    output logic                      r_ready,
    input  agen_uop_pkg::agen_req_s   r_uop,
    input  agen_arch_pkg::arch_regs_s r_regs,
    output logic                      a_valid,
    input  logic                      a_ready,
    output agen_uop_pkg::agen_resp_s  a_uop
);

    import agen_arch_pkg::*;
    import agen_uop_pkg::*;

    gpr_view_t view;
    lin_addr_t dst_addr;
    lin_addr_t src_addr;
    operand_t op0;
    operand_t op1;
    logic op0_is_reg;
    logic op0_is_segment;
    logic op1_is_reg;
    logic op1_is_mem;
    agen_resp_s resp;

    reg_size_selector u_reg_size_selector (
        .size (r_uop.size),
        .regs (r_regs),
        .view (view)
    );

    string_address_unit u_string_address_unit (
        .regs               (r_regs),
        .seg_override       (r_uop.seg_override),
        .seg_override_valid (r_uop.seg_override_valid),
        .dst_addr           (dst_addr),
        .src_addr           (src_addr)
    );

    // op0 has no address flag, its string address goes to the store side
    operand_mux u_op0_mux (
        .src        (r_uop.op0_src),
        .reg_sel    (r_uop.op0_reg),
        .view       (view),
        .regs       (r_regs),
        .imm        (r_uop.imm),
        .mem_addr   (dst_addr),
        .operand    (op0),
        .is_reg     (op0_is_reg),
        .is_segment (op0_is_segment),
        .is_mem     ()
    );

    operand_mux u_op1_mux (
        .src        (r_uop.op1_src),
        .reg_sel    (r_uop.op1_reg),
        .view       (view),
        .regs       (r_regs),
        .imm        (r_uop.imm),
        .mem_addr   (src_addr),
        .operand    (op1),
        .is_reg     (op1_is_reg),
        .is_segment (),
        .is_mem     (op1_is_mem)
    );

    uop_assembler u_uop_assembler (
        .req            (r_uop),
        .op0            (op0),
        .op1            (op1),
        .op0_is_reg     (op0_is_reg),
        .op0_is_segment (op0_is_segment),
        .op1_is_reg     (op1_is_reg),
        .op1_is_mem     (op1_is_mem),
        .resp           (resp)
    );

    pipe_stage u_pipe_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (resp),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_data  (a_uop)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
// Clock and reset generator for the testbench
// 4 ns clock, reset held low for the first 16 rising edges

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/agen_assertions.sv ====
// Handshake assertions for the address generation stage
// bound into agen_top, covers stall stability, flush and output origin

`timescale 1ns/1ps
`default_nettype none

module agen_assertions (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     flush,
    input logic                     r_valid,
    input logic                     r_ready,
    input logic                     a_valid,
    input logic                     a_ready,
    input agen_uop_pkg::agen_resp_s a_uop
);

    int unsigned fail_count = 0;

    // held entry stays put while the consumer stalls
    stable_when_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        a_valid && !a_ready && !flush |=> a_valid && $stable(a_uop))
    else begin
        $error("a_uop changed or dropped under back-pressure");
        fail_count++;
    end

    empty_after_flush: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !a_valid)
    else begin
        $error("a_valid high in the cycle after flush");
        fail_count++;
    end

    // a fresh output entry needs an accepted request one cycle before
    output_has_source: assert property (@(posedge clk) disable iff (!arst_n)
        a_valid && !$past(a_valid && !a_ready) |-> $past(r_valid && r_ready))
    else begin
        $error("output entry without an accepted request");
        fail_count++;
    end

endmodule

bind agen_top agen_assertions u_agen_assertions (
    .clk     (clk),
    .arst_n  (arst_n),
    .flush   (flush),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .a_uop   (a_uop)
);

`default_nettype wire

// ==== testbench/tb_agen.sv ====
// Testbench for the address generation stage
// directed and random micro-ops against a reference model, with stalls and flushes

`timescale 1ns/1ps
`default_nettype none

module tb_agen;

    import agen_arch_pkg::*;
    import agen_uop_pkg::*;

    localparam int SEED = 6;
    localparam int TIMEOUT = 200;
    localparam int REQ_W = $bits(agen_req_s);

    typedef logic [$bits(agen_resp_s)-1:0] resp_bits_t;

    logic clk;
    logic arst_n;
    logic flush;
    logic r_valid;
    logic r_ready;
    agen_req_s r_uop;
    arch_regs_s r_regs;
    logic a_valid;
    logic a_ready;
    agen_resp_s a_uop;

    logic stall_en = 1'b0;
    logic latency_due = 1'b0;
    string test_name = "reset";
    agen_resp_s expected_q[$];
    string name_q[$];
    int checks = 0;
    int mismatches = 0;
    int timeouts = 0;
    int other_errors = 0;

    tb_clock u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    agen_top i_agen_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .flush   (flush),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_uop   (r_uop),
        .r_regs  (r_regs),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .a_uop   (a_uop)
    );

    function automatic seg_sel_t seg_by_code(arch_regs_s regs, logic [2:0] code);
        case (code)
            SEG_ES: return regs.es;
            SEG_CS: return regs.cs;
            SEG_SS: return regs.ss;
            SEG_DS: return regs.ds;
            SEG_FS: return regs.fs;
            SEG_GS: return regs.gs;
            default: return 16'd0;
        endcase
    endfunction

    function automatic operand_t sized_gpr(arch_regs_s regs, reg_idx_t idx, op_size_t size);
        gpr_t full;
        gpr_t byte_src;
        case (idx)
            3'd0: full = regs.eax;
            3'd1: full = regs.ecx;
            3'd2: full = regs.edx;
            3'd3: full = regs.ebx;
            3'd4: full = regs.esp;
            3'd5: full = regs.ebp;
            3'd6: full = regs.esi;
            default: full = regs.edi;
        endcase
        // byte indexes 4..7 are ah, ch, dh, bh
        case (idx[1:0])
            2'd0: byte_src = regs.eax;
            2'd1: byte_src = regs.ecx;
            2'd2: byte_src = regs.edx;
            default: byte_src = regs.ebx;
        endcase
        if (size == SIZE_32) return {32'd0, full};
        if (size == SIZE_16) return {48'd0, full[15:0]};
        if (size == SIZE_8) return idx[2] ? {56'd0, byte_src[15:8]} : {56'd0, byte_src[7:0]};
        return 64'd0;
    endfunction

    function automatic operand_t src_operand(op_src_t src, reg_idx_t idx, agen_req_s req,
                                             arch_regs_s regs, lin_addr_t addr);
        case (src)
            SRC_REG: return sized_gpr(regs, idx, req.size);
            SRC_SEG: return {48'd0, seg_by_code(regs, idx)};
            SRC_IMM: return {16'd0, req.imm};
            SRC_MEM: return {32'd0, addr};
            default: return 64'd0;
        endcase
    endfunction

    // expected stage result for one request
    function automatic agen_resp_s ref_agen(agen_req_s req, arch_regs_s regs);
        agen_resp_s resp;
        lin_addr_t es_di;
        lin_addr_t ds_si;
        seg_sel_t src_seg;
        logic pop;
        pop = req.stack_op[1];
        es_di = lin_addr_t'(regs.es) * 16 + regs.edi;
        src_seg = req.seg_override_valid ? seg_by_code(regs, req.seg_override) : regs.ds;
        ds_si = lin_addr_t'(src_seg) * 16 + regs.esi;
        resp = '0;
        resp.size = req.size;
        resp.set_d_flag = req.set_d_flag;
        resp.clear_d_flag = req.clear_d_flag;
        resp.op0 = src_operand(req.op0_src, req.op0_reg, req, regs, es_di);
        resp.op1 = pop ? {32'd0, req.stack_address}
                       : src_operand(req.op1_src, req.op1_reg, req, regs, ds_si);
        resp.op0_reg = req.op0_reg;
        resp.op1_reg = req.op1_reg;
        resp.op0_is_reg = (req.op0_src == SRC_REG);
        resp.op0_is_segment = (req.op0_src == SRC_SEG);
        resp.op1_is_reg = (req.op1_src == SRC_REG);
        resp.op1_is_address = (req.op1_src == SRC_MEM) || pop;
        resp.imm = req.imm;
        resp.alu_op = req.alu_op;
        resp.flag_0 = req.flag_0;
        resp.flag_1 = req.flag_1;
        resp.stack_op = req.stack_op;
        resp.stack_address = req.stack_address;
        resp.pc = req.pc;
        resp.branch_taken = req.branch_taken;
        resp.opcode = req.opcode;
        resp.to_sys_controller = (req.op0_src == SRC_SYS);
        return resp;
    endfunction

    function automatic agen_req_s random_uop();
        logic [191:0] bits;
        agen_req_s req;
        bits = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
        req = bits[REQ_W-1:0];
        req.stack_op[1] = 1'b0;
        return req;
    endfunction

    function automatic arch_regs_s fill_regs();
        arch_regs_s regs;
        regs.eax = $urandom();
        regs.ecx = $urandom();
        regs.edx = $urandom();
        regs.ebx = $urandom();
        regs.esp = $urandom();
        regs.ebp = $urandom();
        regs.esi = $urandom();
        regs.edi = $urandom();
        regs.es = seg_sel_t'($urandom());
        regs.cs = seg_sel_t'($urandom());
        regs.ss = seg_sel_t'($urandom());
        regs.ds = seg_sel_t'($urandom());
        regs.fs = seg_sel_t'($urandom());
        regs.gs = seg_sel_t'($urandom());
        return regs;
    endfunction

    task automatic check_value(input string name, input resp_bits_t expected,
                               input resp_bits_t actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    // hold the request until the stage takes it
    task automatic send_req(input agen_req_s req, input arch_regs_s regs);
        int waited;
        waited = 0;
        r_valid <= 1'b1;
        r_uop <= req;
        r_regs <= regs;
        @(posedge clk);
        while (!r_ready && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!r_ready) begin
            report_timeout("r_ready");
        end
        r_valid <= 1'b0;
    endtask

    task automatic flush_cycle(input logic with_req);
        flush <= 1'b1;
        if (with_req) begin
            r_valid <= 1'b1;
            r_uop <= random_uop();
            r_regs <= fill_regs();
        end
        @(posedge clk);
        flush <= 1'b0;
        r_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((expected_q.size() != 0 || a_valid) && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0 || a_valid) begin
            report_timeout("the output to drain");
        end
    endtask

    initial begin
        a_ready = 1'b0;
        forever begin
            @(posedge clk);
            a_ready <= stall_en ? (($urandom() % 4) != 0) : 1'b1;
        end
    end

    // pops on output transfers, drops entries lost to flush, pushes accepted requests
    always @(posedge clk) begin : scoreboard
        agen_resp_s expected;
        string name;
        if (arst_n) begin
            if (latency_due) begin
                check_value("latency", resp_bits_t'(1'b1), resp_bits_t'(a_valid));
            end
            latency_due = 1'b0;
            if (a_valid && (a_ready || flush)) begin
                if (expected_q.size() == 0) begin
                    other_errors++;
                    $display("output entry arrived with no request expected");
                end else begin
                    expected = expected_q.pop_front();
                    name = name_q.pop_front();
                    if (a_ready) begin
                        check_value(name, resp_bits_t'(expected), resp_bits_t'(a_uop));
                    end
                end
            end
            if (r_valid && r_ready && !flush) begin
                expected_q.push_back(ref_agen(r_uop, r_regs));
                name_q.push_back(test_name);
                latency_due = 1'b1;
            end
        end
    end

    initial begin
        agen_req_s req;
        int waited;
        void'($urandom(SEED));
        flush = 1'b0;
        r_valid = 1'b0;
        r_uop = '0;
        r_regs = '0;
        waited = 0;
        while (arst_n !== 1'b1 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            report_timeout("reset release");
        end

        test_name <= "register";
        for (int s = 0; s < 8; s++) begin
            for (int i = 0; i < 8; i++) begin
                req = random_uop();
                req.size = op_size_t'(s);
                req.op0_src = SRC_REG;
                req.op0_reg = reg_idx_t'(i);
                req.op1_src = SRC_REG;
                req.op1_reg = reg_idx_t'(7 - i);
                send_req(req, fill_regs());
            end
        end

        test_name <= "segment_immediate";
        for (int i = 0; i < 8; i++) begin
            req = random_uop();
            req.op0_src = SRC_SEG;
            req.op0_reg = reg_idx_t'(i);
            req.op1_src = SRC_IMM;
            send_req(req, fill_regs());
        end

        test_name <= "string_address";
        for (int i = 0; i < 16; i++) begin
            req = random_uop();
            req.op0_src = SRC_MEM;
            req.op1_src = SRC_MEM;
            send_req(req, fill_regs());
        end

        test_name <= "pop_system";
        for (int i = 0; i < 16; i++) begin
            req = random_uop();
            case (i % 4)
                0: begin
                    req.stack_op = {1'b1, 1'($urandom())};
                    req.op1_src = op_src_t'($urandom());
                end
                1: begin
                    req.op0_src = SRC_SYS;
                    req.op1_src = 3'd3;
                end
                2: begin
                    req.op0_src = 3'd4;
                    req.op1_src = 3'd3;
                end
                default: begin
                    req.op0_src = SRC_SYS;
                    req.op1_src = 3'd4;
                end
            endcase
            send_req(req, fill_regs());
        end

        test_name <= "backpressure";
        stall_en <= 1'b1;
        for (int i = 0; i < 150; i++) begin
            req = random_uop();
            req.stack_op[1] = (($urandom() % 4) == 0);
            send_req(req, fill_regs());
        end

        // flush right after an accept, sometimes with a request in the flush cycle
        test_name <= "flush";
        for (int i = 0; i < 20; i++) begin
            send_req(random_uop(), fill_regs());
            send_req(random_uop(), fill_regs());
            flush_cycle(i % 2 == 1);
        end
        for (int i = 0; i < 20; i++) begin
            send_req(random_uop(), fill_regs());
        end

        stall_en <= 1'b0;
        wait_drain();
        repeat (4) @(posedge clk);
        if (expected_q.size() != 0) begin
            $display("%0d expected results never reached the output", expected_q.size());
        end
        $display("checks %0d, mismatches %0d, timeouts %0d, other errors %0d, asserts %0d",
                 checks, mismatches, timeouts, other_errors,
                 i_agen_top.u_agen_assertions.fail_count);
        if (mismatches == 0 && timeouts == 0 && other_errors == 0 && expected_q.size() == 0
                && i_agen_top.u_agen_assertions.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/agen_arch_pkg.sv
src/agen_uop_pkg.sv
src/reg_size_selector.sv
src/string_address_unit.sv
src/operand_mux.sv
src/uop_assembler.sv
src/pipe_stage.sv
src/agen_top.sv
testbench/tb_clock.sv
testbench/agen_assertions.sv
testbench/tb_agen.sv

// ==== Makefile ====
TOP := tb_agen

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o sim_agen
	./obj_dir/sim_agen +verilator+error+limit+100 | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
